/* common/trs_io_pkg.sv */
package trs_io_pkg;

  // sizes
  localparam int ram_aw   = 12;                // 4 kbyte shared ram, 64 pages of 64
  localparam int trs_aw   = 16;                // z80 address bus
  localparam int bp_slots = 8;
  localparam int bp_iw    = $clog2(bp_slots);  // slot index width

  // esp command codes, numbering kept from the full trs-io command set
  localparam logic [7:0] cmd_get_cookie       = 8'd0;
  localparam logic [7:0] cmd_bram_poke        = 8'd1;
  localparam logic [7:0] cmd_bram_peek        = 8'd2;
  localparam logic [7:0] cmd_set_breakpoint   = 8'd6;
  localparam logic [7:0] cmd_clear_breakpoint = 8'd7;
  localparam logic [7:0] cmd_enable_bp        = 8'd11;
  localparam logic [7:0] cmd_disable_bp       = 8'd12;
  localparam logic [7:0] cmd_xray_resume      = 8'd13;
  localparam logic [7:0] cmd_get_version      = 8'd15;
  localparam logic [7:0] cmd_set_led          = 8'd26;

  // reply constants
  localparam logic [7:0] cookie_val  = 8'haf;
  localparam logic [7:0] version_val = {3'd0, 5'd3};  // major 0, minor 3

  // parser to breakpoint unit ops
  localparam logic [2:0] bp_op_set     = 3'd0;
  localparam logic [2:0] bp_op_clear   = 3'd1;
  localparam logic [2:0] bp_op_enable  = 3'd2;
  localparam logic [2:0] bp_op_disable = 3'd3;
  localparam logic [2:0] bp_op_resume  = 3'd4;

  // parser states
  localparam logic ps_idle = 1'b0;
  localparam logic ps_read = 1'b1;  // collecting parameter bytes

  // the three parameter bytes, first received byte in the top bits
  typedef union packed {
    struct packed {
      logic [7:0] addr_lo;
      logic [7:0] addr_hi;
      logic [7:0] data;     // poke only
    } mem_view;
    struct packed {
      logic [7:0] slot;
      logic [7:0] addr_lo;
      logic [7:0] addr_hi;
    } bp_view;
  } cmd_args_u;

endpackage

/* spi/spi_byte_link.sv */
`timescale 1ns/1ns

module spi_byte_link (
  input  logic       clk,
  input  logic       cass_out_sel_n,
  input  logic       sck,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  output logic [7:0] rx_byte,
  output logic       rx_valid,
  input  logic [7:0] tx_byte,
  input  logic       tx_load
);

  logic [2:0] sck_r;
  logic [2:0] cs_r;
  logic [2:0] mosi_r;
  logic       sck_rise;
  logic       sck_fall;
  logic       cs_active;
  logic [2:0] bitcnt;
  logic [7:0] rx_sr;
  logic [7:0] tx_hold;  // reply waiting for the byte boundary
  logic       tx_pend;
  logic [7:0] tx_sr;

  // spi runs mode 0 from the esp, sampled on clk
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_r  <= 3'b000;
      cs_r   <= 3'b111;  // deselected
      mosi_r <= 3'b000;
    end else begin
      sck_r  <= {sck_r[1:0], sck};
      cs_r   <= {cs_r[1:0], cs_n};
      mosi_r <= {mosi_r[1:0], mosi};
    end
  end

  assign sck_rise  = (sck_r[2:1] == 2'b01);
  assign sck_fall  = (sck_r[2:1] == 2'b10);
  assign cs_active = ~cs_r[2];

  // receive side
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bitcnt   <= 3'd0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= cs_active && sck_rise && (bitcnt == 3'd7);  // eighth bit in
      if (!cs_active)
        bitcnt <= 3'd0;
      else if (sck_rise)
        bitcnt <= bitcnt + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (sck_rise)
      rx_sr <= {rx_sr[6:0], mosi_r[2]};  // mosi as it stood before the edge
  end

  assign rx_byte = rx_sr;

  // transmit side, reply goes out during the byte after the command
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      tx_pend <= 1'b0;
      tx_sr   <= 8'h00;
    end else begin
      if (!cs_active) begin
        tx_sr <= 8'h00;
      end else if (sck_fall) begin
        if (bitcnt == 3'd0)
          tx_sr <= tx_pend ? tx_hold : 8'h00;  // boundary, msb goes out now
        else
          tx_sr <= {tx_sr[6:0], 1'b0};
      end
      if (tx_load)
        tx_pend <= 1'b1;
      else if (cs_active && sck_fall && (bitcnt == 3'd0))
        tx_pend <= 1'b0;  // consumed
    end
  end

  always_ff @(posedge clk) begin
    if (tx_load)
      tx_hold <= tx_byte;
  end

  assign miso = cs_active & tx_sr[7];  // low when deselected

endmodule

/* spi/esp_cmd_parser.sv */
`timescale 1ns/1ns

module esp_cmd_parser (
  input  logic                          clk,
  input  logic                          cass_out_sel_n,
  input  logic [7:0]                    rx_byte,
  input  logic                          rx_valid,
  output logic [7:0]                    tx_byte,
  output logic                          tx_load,
  output logic                          bp_cmd,
  output logic [2:0]                    bp_op,
  output trs_io_pkg::cmd_args_u         bp_args,
  output logic                          esp_req,
  output logic                          esp_we,
  output logic [trs_io_pkg::ram_aw-1:0] esp_addr,
  output logic [7:0]                    esp_wdata,
  input  logic                          esp_gnt,
  input  logic [7:0]                    esp_rdata,
  input  logic                          esp_rvalid,
  output logic [2:0]                    led
);
  import trs_io_pkg::*;

  logic       state;
  logic [7:0] cmd;
  logic [1:0] left;   // parameter bytes still to come
  logic [1:0] idx;
  logic       fire;   // action cycle
  cmd_args_u  args;
  logic [15:0] mem_addr;

  assign bp_args  = args;
  assign mem_addr = {args.mem_view.addr_hi, args.mem_view.addr_lo};

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state <= ps_idle;
      cmd   <= cmd_get_cookie;
      left  <= 2'd0;
      idx   <= 2'd0;
      fire  <= 1'b0;
    end else begin
      fire <= 1'b0;
      if (rx_valid) begin
        if (state == ps_idle) begin
          cmd <= rx_byte;
          idx <= 2'd0;
          case (rx_byte)
            cmd_bram_poke, cmd_set_breakpoint: begin
              left  <= 2'd3;
              state <= ps_read;
            end
            cmd_bram_peek: begin
              left  <= 2'd2;
              state <= ps_read;
            end
            cmd_clear_breakpoint, cmd_set_led: begin
              left  <= 2'd1;
              state <= ps_read;
            end
            cmd_get_cookie, cmd_get_version, cmd_enable_bp,
            cmd_disable_bp, cmd_xray_resume:
              fire <= 1'b1;  // no parameters
            default: ;  // unknown, stay idle
          endcase
        end else begin
          idx <= idx + 2'd1;
          if (left == 2'd1) begin
            fire  <= 1'b1;
            state <= ps_idle;
          end else begin
            left <= left - 2'd1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_valid && (state == ps_read)) begin
      case (idx)
        2'd0:    args[23:16] <= rx_byte;
        2'd1:    args[15:8]  <= rx_byte;
        default: args[7:0]   <= rx_byte;
      endcase
    end
  end

  // breakpoint ops straight from the action cycle
  always_comb begin
    bp_cmd = 1'b0;
    bp_op  = bp_op_set;
    if (fire) begin
      case (cmd)
        cmd_set_breakpoint:   begin bp_cmd = 1'b1; bp_op = bp_op_set;     end
        cmd_clear_breakpoint: begin bp_cmd = 1'b1; bp_op = bp_op_clear;   end
        cmd_enable_bp:        begin bp_cmd = 1'b1; bp_op = bp_op_enable;  end
        cmd_disable_bp:       begin bp_cmd = 1'b1; bp_op = bp_op_disable; end
        cmd_xray_resume:      begin bp_cmd = 1'b1; bp_op = bp_op_resume;  end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      esp_req <= 1'b0;
      esp_we  <= 1'b0;
      led     <= 3'd0;
      tx_load <= 1'b0;
    end else begin
      tx_load <= esp_rvalid;  // peek data is the reply
      if (esp_gnt)
        esp_req <= 1'b0;
      if (fire) begin
        case (cmd)
          cmd_bram_poke: begin
            esp_req <= 1'b1;
            esp_we  <= 1'b1;
          end
          cmd_bram_peek: begin
            esp_req <= 1'b1;
            esp_we  <= 1'b0;
          end
          cmd_set_led:                     led     <= args.bp_view.slot[2:0];  // 1st byte
          cmd_get_cookie, cmd_get_version: tx_load <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire && ((cmd == cmd_bram_poke) || (cmd == cmd_bram_peek))) begin
      esp_addr  <= mem_addr[ram_aw-1:0];  // upper page bits fold onto ram size
      esp_wdata <= args.mem_view.data;
    end
    if (esp_rvalid)
      tx_byte <= esp_rdata;
    else if (fire && (cmd == cmd_get_cookie))
      tx_byte <= cookie_val;
    else if (fire && (cmd == cmd_get_version))
      tx_byte <= version_val;
  end

endmodule

/* logic/breakpoint_unit.sv */
`timescale 1ns/1ns

module breakpoint_unit (
  input  logic                          clk,
  input  logic                          cass_out_sel_n,
  input  logic                          bp_cmd,
  input  logic [2:0]                    bp_op,
  input  trs_io_pkg::cmd_args_u         bp_args,
  input  logic                          rd_start,
  input  logic [trs_io_pkg::trs_aw-1:0] rd_addr,
  output logic                          bp_stop,
  output logic [trs_io_pkg::bp_iw-1:0]  bp_idx
);
  import trs_io_pkg::*;

  logic [trs_aw-1:0]   bp_addr [bp_slots];
  logic [bp_slots-1:0] bp_act;
  logic                bp_en;
  logic [bp_iw-1:0]    slot;
  logic                hit;
  logic [bp_iw-1:0]    hit_idx;

  assign slot = bp_args.bp_view.slot[bp_iw-1:0];

  // downward scan so the lowest matching slot is left in hit_idx
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = bp_slots - 1; i >= 0; i--) begin
      if (bp_act[i] && (bp_addr[i] == rd_addr)) begin
        hit     = 1'b1;
        hit_idx = bp_iw'(i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bp_cmd && (bp_op == bp_op_set))
      bp_addr[slot] <= {bp_args.bp_view.addr_hi, bp_args.bp_view.addr_lo};
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bp_act  <= '0;
      bp_en   <= 1'b0;
      bp_stop <= 1'b0;
      bp_idx  <= '0;
    end else begin
      if (bp_cmd) begin
        case (bp_op)
          bp_op_set:     bp_act[slot] <= 1'b1;
          bp_op_clear:   bp_act[slot] <= 1'b0;
          bp_op_enable:  bp_en        <= 1'b1;
          bp_op_disable: bp_en        <= 1'b0;
          bp_op_resume:  bp_stop      <= 1'b0;
          default: ;
        endcase
      end
      if (rd_start && bp_en && !bp_stop && hit) begin
        bp_stop <= 1'b1;  // held until resume
        bp_idx  <= hit_idx;
      end
    end
  end

endmodule

/* logic/trs_mem_port.sv */
`timescale 1ns/1ns

module trs_mem_port (
  input  logic                          clk,
  input  logic                          cass_out_sel_n,
  input  logic [trs_io_pkg::trs_aw-1:0] trs_a,
  input  logic                          trs_rd_n,
  input  logic                          trs_wr_n,
  input  logic [7:0]                    trs_d_in,
  output logic [7:0]                    trs_d_out,
  output logic                          trs_d_oe,
  output logic                          trs_req,
  output logic                          trs_we,
  output logic [trs_io_pkg::ram_aw-1:0] trs_addr,
  output logic [7:0]                    trs_wdata,
  input  logic                          trs_gnt,
  input  logic [7:0]                    trs_rdata,
  input  logic                          trs_rvalid,
  output logic                          rd_start,
  output logic [trs_io_pkg::trs_aw-1:0] rd_addr
);
  import trs_io_pkg::*;

  logic [2:0] rd_r;
  logic [2:0] wr_r;
  logic       rd_fall;
  logic       rd_rise;
  logic       wr_fall;

  assign rd_fall = (rd_r[2:1] == 2'b10);
  assign rd_rise = (rd_r[2:1] == 2'b01);
  assign wr_fall = (wr_r[2:1] == 2'b10);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      rd_r     <= 3'b111;
      wr_r     <= 3'b111;
      trs_req  <= 1'b0;
      trs_we   <= 1'b0;
      trs_d_oe <= 1'b0;
      rd_start <= 1'b0;
    end else begin
      rd_r     <= {rd_r[1:0], trs_rd_n};
      wr_r     <= {wr_r[1:0], trs_wr_n};
      rd_start <= rd_fall;
      if (trs_gnt)
        trs_req <= 1'b0;
      if (rd_fall || wr_fall) begin
        trs_req <= 1'b1;  // one ram access per strobe
        trs_we  <= wr_fall;
      end
      if (rd_rise)
        trs_d_oe <= 1'b0;
      else if (trs_rvalid)
        trs_d_oe <= 1'b1;
    end
  end

  // address and data are stable by the time the strobe is seen low
  always_ff @(posedge clk) begin
    if (rd_fall || wr_fall)
      trs_addr <= trs_a[ram_aw-1:0];
    if (wr_fall)
      trs_wdata <= trs_d_in;
    if (rd_fall)
      rd_addr <= trs_a;  // full address for the comparators
    if (trs_rvalid)
      trs_d_out <= trs_rdata;
  end

endmodule

/* logic/mem_arbiter.sv */
`timescale 1ns/1ns

module mem_arbiter (
  input  logic                          clk,
  input  logic                          cass_out_sel_n,
  input  logic                          trs_req,
  input  logic                          trs_we,
  input  logic [trs_io_pkg::ram_aw-1:0] trs_addr,
  input  logic [7:0]                    trs_wdata,
  output logic                          trs_gnt,
  output logic [7:0]                    trs_rdata,
  output logic                          trs_rvalid,
  input  logic                          esp_req,
  input  logic                          esp_we,
  input  logic [trs_io_pkg::ram_aw-1:0] esp_addr,
  input  logic [7:0]                    esp_wdata,
  output logic                          esp_gnt,
  output logic [7:0]                    esp_rdata,
  output logic                          esp_rvalid,
  output logic                          ram_en,
  output logic                          ram_we,
  output logic [trs_io_pkg::ram_aw-1:0] ram_addr,
  output logic [7:0]                    ram_wdata,
  input  logic [7:0]                    ram_rdata
);

  // bus side always first, the z80 cannot be stretched
  assign trs_gnt = trs_req;
  assign esp_gnt = esp_req & ~trs_req;

  assign ram_en    = trs_gnt | esp_gnt;
  assign ram_we    = trs_gnt ? trs_we    : (esp_gnt & esp_we);
  assign ram_addr  = trs_gnt ? trs_addr  : esp_addr;
  assign ram_wdata = trs_gnt ? trs_wdata : esp_wdata;

  // return tag, reads only
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      trs_rvalid <= 1'b0;
      esp_rvalid <= 1'b0;
    end else begin
      trs_rvalid <= trs_gnt & ~trs_we;
      esp_rvalid <= esp_gnt & ~esp_we;
    end
  end

  assign trs_rdata = ram_rdata;  // only meaningful with rvalid
  assign esp_rdata = ram_rdata;

endmodule

/* logic/shared_ram.sv */
`timescale 1ns/1ns

module shared_ram (
  input  logic                          clk,
  input  logic                          en,
  input  logic                          we,
  input  logic [trs_io_pkg::ram_aw-1:0] addr,
  input  logic [7:0]                    wdata,
  output logic [7:0]                    rdata
);
  import trs_io_pkg::*;

  logic [7:0] mem [2**ram_aw];

  always_ff @(posedge clk) begin
    if (en) begin
      if (we)
        mem[addr] <= wdata;
      rdata <= mem[addr];  // read first
    end
  end

endmodule

/* logic/trs_io_top.sv */
`timescale 1ns/1ns

module trs_io_top (
  input  logic                          clk,
  input  logic                          cass_out_sel_n,
  input  logic                          sck,
  input  logic                          cs_n,
  input  logic                          mosi,
  output logic                          miso,
  input  logic [trs_io_pkg::trs_aw-1:0] trs_a,
  input  logic                          trs_rd_n,
  input  logic                          trs_wr_n,
  input  logic [7:0]                    trs_d_in,
  output logic [7:0]                    trs_d_out,
  output logic                          trs_d_oe,
  output logic [2:0]                    led,
  output logic                          bp_stop,
  output logic [trs_io_pkg::bp_iw-1:0]  bp_idx
);
  import trs_io_pkg::*;

  logic [7:0]        rx_byte;
  logic              rx_valid;
  logic [7:0]        tx_byte;
  logic              tx_load;
  logic              bp_cmd;
  logic [2:0]        bp_op;
  cmd_args_u         bp_args;
  logic              esp_req;
  logic              esp_we;
  logic [ram_aw-1:0] esp_addr;
  logic [7:0]        esp_wdata;
  logic              esp_gnt;
  logic [7:0]        esp_rdata;
  logic              esp_rvalid;
  logic              trs_req;
  logic              trs_we;
  logic [ram_aw-1:0] trs_addr;
  logic [7:0]        trs_wdata;
  logic              trs_gnt;
  logic [7:0]        trs_rdata;
  logic              trs_rvalid;
  logic              rd_start;
  logic [trs_aw-1:0] rd_addr;
  logic              ram_en;
  logic              ram_we;
  logic [ram_aw-1:0] ram_addr;
  logic [7:0]        ram_wdata;
  logic [7:0]        ram_rdata;

  spi_byte_link spi0 (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n),
    .sck(sck), .cs_n(cs_n), .mosi(mosi), .miso(miso),
    .rx_byte(rx_byte), .rx_valid(rx_valid), .tx_byte(tx_byte), .tx_load(tx_load)
  );

  esp_cmd_parser parser0 (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n),
    .rx_byte(rx_byte), .rx_valid(rx_valid), .tx_byte(tx_byte), .tx_load(tx_load),
    .bp_cmd(bp_cmd), .bp_op(bp_op), .bp_args(bp_args),
    .esp_req(esp_req), .esp_we(esp_we), .esp_addr(esp_addr), .esp_wdata(esp_wdata),
    .esp_gnt(esp_gnt), .esp_rdata(esp_rdata), .esp_rvalid(esp_rvalid),
    .led(led)
  );

  breakpoint_unit bp0 (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n),
    .bp_cmd(bp_cmd), .bp_op(bp_op), .bp_args(bp_args),
    .rd_start(rd_start), .rd_addr(rd_addr), .bp_stop(bp_stop), .bp_idx(bp_idx)
  );

  trs_mem_port port0 (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n),
    .trs_a(trs_a), .trs_rd_n(trs_rd_n), .trs_wr_n(trs_wr_n),
    .trs_d_in(trs_d_in), .trs_d_out(trs_d_out), .trs_d_oe(trs_d_oe),
    .trs_req(trs_req), .trs_we(trs_we), .trs_addr(trs_addr), .trs_wdata(trs_wdata),
    .trs_gnt(trs_gnt), .trs_rdata(trs_rdata), .trs_rvalid(trs_rvalid),
    .rd_start(rd_start), .rd_addr(rd_addr)
  );

  mem_arbiter arb0 (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n),
    .trs_req(trs_req), .trs_we(trs_we), .trs_addr(trs_addr), .trs_wdata(trs_wdata),
    .trs_gnt(trs_gnt), .trs_rdata(trs_rdata), .trs_rvalid(trs_rvalid),
    .esp_req(esp_req), .esp_we(esp_we), .esp_addr(esp_addr), .esp_wdata(esp_wdata),
    .esp_gnt(esp_gnt), .esp_rdata(esp_rdata), .esp_rvalid(esp_rvalid),
    .ram_en(ram_en), .ram_we(ram_we), .ram_addr(ram_addr),
    .ram_wdata(ram_wdata), .ram_rdata(ram_rdata)
  );

  shared_ram ram0 (
    .clk(clk), .en(ram_en), .we(ram_we), .addr(ram_addr),
    .wdata(ram_wdata), .rdata(ram_rdata)
  );

endmodule

/* sim/trs_io_chk.sv */
`timescale 1ns/1ns

module trs_io_chk (
  input logic clk,
  input logic rst_n,
  input logic trs_req,
  input logic esp_req,
  input logic trs_gnt,
  input logic esp_gnt,
  input logic rd_n,
  input logic d_oe
);

  // single ram port
  one_grant: assert property (@(posedge clk) disable iff (!rst_n) !(trs_gnt && esp_gnt))
    else $error("both ram grants high");

  // a grant consumes its request, so no access is served twice
  trs_gnt_req: assert property (@(posedge clk) disable iff (!rst_n) trs_gnt |=> !trs_req)
    else $error("bus request still high after its grant");

  esp_gnt_req: assert property (@(posedge clk) disable iff (!rst_n) esp_gnt |=> !esp_req)
    else $error("esp request still high after its grant");

  // strobe back high long enough, drive must be gone
  oe_release: assert property (@(posedge clk) disable iff (!rst_n) rd_n [*4] |-> !d_oe)
    else $error("data bus still driven after read strobe rose");

endmodule

bind trs_io_top trs_io_chk top_chk (
  .clk(clk), .rst_n(cass_out_sel_n), .trs_req(trs_req), .esp_req(esp_req),
  .trs_gnt(trs_gnt), .esp_gnt(esp_gnt), .rd_n(trs_rd_n), .d_oe(trs_d_oe)
);

/* sim/trs_io_tb.sv */
`timescale 1ns/1ns

module trs_io_tb;
  import trs_io_pkg::*;

  localparam int n_rand    = 8;                     // random pokes per test
  localparam int half_sck  = 8;                     // sck half period in clocks
  localparam int n_cmds    = 30 + n_rand * 4;       // spi commands over all tests
  localparam int spi_bytes = 60 + n_rand * 18;
  localparam int bus_ops   = 20 + n_rand * 10;
  localparam int limit_ns  = 2 * (spi_bytes * 16 * half_sck + n_cmds * 20 + bus_ops * 20) * 4;

  logic              clk;
  logic              cass_out_sel_n;
  logic              sck;
  logic              cs_n;
  logic              mosi;
  logic              miso;
  logic [trs_aw-1:0] trs_a;
  logic              trs_rd_n;
  logic              trs_wr_n;
  logic [7:0]        trs_d_in;
  logic [7:0]        trs_d_out;
  logic              trs_d_oe;
  logic [2:0]        led;
  logic              bp_stop;
  logic [bp_iw-1:0]  bp_idx;

  // reference state
  logic [7:0]          model_ram [2**ram_aw];
  logic [trs_aw-1:0]   model_bp_addr [bp_slots];
  logic [bp_slots-1:0] model_bp_act;
  logic                model_bp_en;

  logic [15:0] lfsr = 16'd94;
  int          errors = 0;
  int          checks = 0;
  string       what_q[$];   // pending byte compares
  logic [7:0]  got_q[$];
  logic [7:0]  exp_q[$];

  trs_io_top dut0 (
    .clk(clk), .cass_out_sel_n(cass_out_sel_n),
    .sck(sck), .cs_n(cs_n), .mosi(mosi), .miso(miso),
    .trs_a(trs_a), .trs_rd_n(trs_rd_n), .trs_wr_n(trs_wr_n),
    .trs_d_in(trs_d_in), .trs_d_out(trs_d_out), .trs_d_oe(trs_d_oe),
    .led(led), .bp_stop(bp_stop), .bp_idx(bp_idx)
  );

  always #2 clk = ~clk;  // 4 ns period

  // 16 bit fibonacci, taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[14:0], lfsr[0]};  // one step per bit
    end
  endtask

  function automatic logic [7:0] expect_byte(input logic [ram_aw-1:0] a);
    return model_ram[a];
  endfunction

  // lowest active slot wins, top bit says stop
  function automatic logic [bp_iw:0] expect_stop(input logic [trs_aw-1:0] a);
    for (int i = 0; i < bp_slots; i++) begin
      if (model_bp_en && model_bp_act[i] && (model_bp_addr[i] == a))
        return {1'b1, bp_iw'(i)};
    end
    return '0;
  endfunction

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR %0t ns: %s got 0x%02h, expected 0x%02h", $time, what, got, exp);
    end
  endtask

  task automatic check_stop(input string what, input logic got_stop,
                            input logic [bp_iw-1:0] got_idx, input logic [bp_iw:0] exp);
    checks++;
    if ((got_stop !== exp[bp_iw]) || (exp[bp_iw] && (got_idx !== exp[bp_iw-1:0]))) begin
      errors++;
      $display("ERROR %0t ns: %s got stop %b slot %0d, expected stop %b slot %0d",
               $time, what, got_stop, got_idx, exp[bp_iw], exp[bp_iw-1:0]);
    end
  endtask

  task automatic post_result(input string what, input logic [7:0] got, input logic [7:0] exp);
    what_q.push_back(what);
    got_q.push_back(got);
    exp_q.push_back(exp);
  endtask

  // comparing process
  initial begin
    forever begin
      @(negedge clk);
      while (got_q.size() > 0)
        check_byte(what_q.pop_front(), got_q.pop_front(), exp_q.pop_front());
    end
  end

  // mode 0, miso sampled as sck rises
  task automatic spi_byte(input logic [7:0] tx, output logic [7:0] rx);
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      repeat (half_sck) @(negedge clk);
      sck   = 1'b1;
      rx[i] = miso;
      repeat (half_sck) @(negedge clk);
      sck = 1'b0;
    end
  endtask

  // command, n parameters, then a dummy byte that carries the reply
  task automatic spi_cmd(input logic [7:0] cmd, input logic [7:0] p0, input logic [7:0] p1,
                         input logic [7:0] p2, input int n, output logic [7:0] reply);
    logic [7:0] prm [3];
    logic [7:0] junk;
    prm[0] = p0;
    prm[1] = p1;
    prm[2] = p2;
    cs_n = 1'b0;
    repeat (4) @(negedge clk);
    spi_byte(cmd, junk);
    for (int i = 0; i < n; i++)
      spi_byte(prm[i], junk);
    spi_byte(8'h00, reply);
    repeat (4) @(negedge clk);
    cs_n = 1'b1;
    repeat (8) @(negedge clk);
  endtask

  task automatic esp_poke(input logic [ram_aw-1:0] a, input logic [7:0] d);
    logic [7:0] r;
    spi_cmd(cmd_bram_poke, a[7:0], 8'(a >> 8), d, 3, r);
    model_ram[a] = d;
  endtask

  task automatic esp_peek(input logic [ram_aw-1:0] a, input string what);
    logic [7:0] r;
    spi_cmd(cmd_bram_peek, a[7:0], 8'(a >> 8), 8'h00, 2, r);
    post_result(what, r, expect_byte(a));
  endtask

  task automatic bus_write(input logic [trs_aw-1:0] a, input logic [7:0] d);
    trs_a    = a;
    trs_d_in = d;
    trs_wr_n = 1'b0;
    repeat (12) @(negedge clk);
    trs_wr_n = 1'b1;
    repeat (4) @(negedge clk);
    model_ram[a[ram_aw-1:0]] = d;
  endtask

  // waits for the data drive, bounded by the strobe length
  task automatic bus_read(input logic [trs_aw-1:0] a, output logic [7:0] d);
    int n;
    n        = 0;
    trs_a    = a;
    trs_rd_n = 1'b0;
    while (!trs_d_oe && (n < 12)) begin
      @(negedge clk);
      n++;
    end
    if (!trs_d_oe) begin
      errors++;
      $display("the bus read of address 0x%04h never drove the data bus", a);
    end else if (n > 6) begin
      errors++;
      $display("ERROR %0t ns: bus read data came after %0d cycles", $time, n);
    end
    d = trs_d_out;
    repeat (12 - n) @(negedge clk);
    trs_rd_n = 1'b1;
    repeat (4) @(negedge clk);
  endtask

  task automatic bus_read_check(input logic [trs_aw-1:0] a, input string what);
    logic [7:0] d;
    bus_read(a, d);
    post_result(what, d, expect_byte(a[ram_aw-1:0]));
  endtask

  task automatic set_bp(input int slot, input logic [trs_aw-1:0] a);
    logic [7:0] r;
    spi_cmd(cmd_set_breakpoint, 8'(slot), a[7:0], a[15:8], 3, r);
    model_bp_addr[slot] = a;
    model_bp_act[slot]  = 1'b1;
  endtask

  task automatic bp_simple(input logic [7:0] cmd, input int n, input logic [7:0] p0);
    logic [7:0] r;
    spi_cmd(cmd, p0, 8'h00, 8'h00, n, r);
  endtask

  // watchdog
  initial begin
    #(limit_ns);
    $display("timeout after %0d ns with %0d errors so far", limit_ns, errors);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    logic [15:0]       v;
    logic [15:0]       w;
    logic [7:0]        r;
    logic [ram_aw-1:0] pa [n_rand];
    logic [trs_aw-1:0] ba [n_rand];
    logic [ram_aw-1:0] ea [n_rand];
    logic [7:0]        ed [n_rand];
    logic [trs_aw-1:0] hit_a;
    logic [trs_aw-1:0] hit_b;
    logic              esp_done;
    int                k;
    clk            = 1'b0;
    cass_out_sel_n = 1'b0;
    sck            = 1'b0;
    cs_n           = 1'b1;
    mosi           = 1'b0;
    trs_a          = '0;
    trs_rd_n       = 1'b1;
    trs_wr_n       = 1'b1;
    trs_d_in       = 8'h00;
    model_bp_act   = '0;
    model_bp_en    = 1'b0;
    repeat (10) @(negedge clk);
    cass_out_sel_n = 1'b1;
    repeat (4) @(negedge clk);

    post_result("led after reset", {5'd0, led}, 8'h00);
    post_result("oe and miso after reset", {6'd0, trs_d_oe, miso}, 8'h00);
    check_stop("stop after reset", bp_stop, bp_idx, '0);

    // fixed replies
    spi_cmd(cmd_get_cookie, 8'h00, 8'h00, 8'h00, 0, r);
    post_result("cookie", r, 8'haf);
    spi_cmd(cmd_get_version, 8'h00, 8'h00, 8'h00, 0, r);
    post_result("version", r, 8'h03);

    // random pokes then peeks, unknown code in between
    for (int i = 0; i < n_rand; i++) begin
      rand_bits(ram_aw, v);
      rand_bits(8, w);
      pa[i] = v[ram_aw-1:0];
      esp_poke(pa[i], w[7:0]);
    end
    spi_cmd(8'h55, 8'h00, 8'h00, 8'h00, 0, r);
    post_result("reply to unknown code", r, 8'h00);
    for (int i = 0; i < n_rand; i++)
      esp_peek(pa[i], "esp peek after poke");

    // bus to esp and back
    rand_bits(trs_aw, v);
    rand_bits(8, w);
    bus_write(v, w[7:0]);
    esp_peek(v[ram_aw-1:0], "esp peek after bus write");
    rand_bits(ram_aw, v);
    rand_bits(8, w);
    esp_poke(v[ram_aw-1:0], w[7:0]);
    bus_read_check(v, "bus read after esp poke");

    // concurrent traffic, bus side in the upper half, esp in the lower
    for (int i = 0; i < n_rand; i++) begin
      rand_bits(trs_aw, v);
      ba[i] = v | 16'h0800;
      rand_bits(8, w);
      bus_write(ba[i], w[7:0]);
      rand_bits(ram_aw - 1, v);
      ea[i] = v[ram_aw-1:0];
      rand_bits(8, w);
      ed[i] = w[7:0];
    end
    esp_done = 1'b0;
    fork
      begin
        k = 0;
        while (!esp_done) begin  // bus keeps reading for the whole esp run
          bus_read_check(ba[k % n_rand], "concurrent bus read");
          rand_bits(2, v);
          repeat (v[1:0]) @(negedge clk);  // slides the bus phase against the spi
          k++;
        end
      end
      begin
        for (int i = 0; i < n_rand; i++) begin
          esp_poke(ea[i], ed[i]);
          esp_peek(ea[i], "concurrent esp peek");
        end
        esp_done = 1'b1;
      end
    join

    // breakpoints
    hit_a = 16'h4a10;
    hit_b = 16'h1234;
    set_bp(5, hit_a);
    set_bp(2, hit_a);
    set_bp(1, hit_b);
    bp_simple(cmd_enable_bp, 0, 8'h00);
    model_bp_en = 1'b1;
    bus_read(hit_a, r);
    check_stop("stop on shared address", bp_stop, bp_idx, expect_stop(hit_a));
    bp_simple(cmd_xray_resume, 0, 8'h00);
    check_stop("after resume", bp_stop, bp_idx, '0);
    bp_simple(cmd_clear_breakpoint, 1, 8'd2);
    model_bp_act[2] = 1'b0;
    bus_read(hit_a, r);
    check_stop("stop after slot clear", bp_stop, bp_idx, expect_stop(hit_a));
    bp_simple(cmd_xray_resume, 0, 8'h00);
    bp_simple(cmd_disable_bp, 0, 8'h00);
    model_bp_en = 1'b0;
    bus_read(hit_b, r);
    check_stop("read while disabled", bp_stop, bp_idx, expect_stop(hit_b));

    // led takes the low three bits
    bp_simple(cmd_set_led, 1, 8'hfd);
    post_result("led", {5'd0, led}, 8'h05);

    while (got_q.size() > 0)
      @(negedge clk);
    @(negedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* src.f */
common/trs_io_pkg.sv
spi/spi_byte_link.sv
spi/esp_cmd_parser.sv
logic/breakpoint_unit.sv
logic/trs_mem_port.sv
logic/mem_arbiter.sv
logic/shared_ram.sv
logic/trs_io_top.sv
sim/trs_io_chk.sv
sim/trs_io_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= trs_io_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "RESULT: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
